// ==== Bender.yml ====
package:
  name: sprite_video

sources:
  - rtl/sprite_pkg.sv
  - rtl/vga_timing.sv
  - rtl/wb_sprite_regs.sv
  - rtl/sprite_ram.sv
  - rtl/obstacle_sprite.sv
  - rtl/sprite_video_top.sv
  - target: simulation
    files:
      - sim/tb_sprite_video.sv

// ==== all.f ====
rtl/sprite_pkg.sv
rtl/vga_timing.sv
rtl/wb_sprite_regs.sv
rtl/sprite_ram.sv
rtl/obstacle_sprite.sv
rtl/sprite_video_top.sv
sim/tb_sprite_video.sv

// ==== rtl/obstacle_sprite.sv ====
// two-stage obstacle bit generator with scaled sprite lookup, colour key and RGB888 expansion
module obstacle_sprite (
    input  logic                    pix_clk,
    input  logic                    rst_n,
    input  sprite_pkg::coord_t      hcount,
    input  sprite_pkg::coord_t      vcount,
    input  logic                    bright,
    input  sprite_pkg::coord_t      obstacle_x,
    input  sprite_pkg::rgb565_t     sprite_data,
    output sprite_pkg::sprite_idx_t sprite_idx,
    output sprite_pkg::pixel_out_t  pixel_out
);

    import sprite_pkg::*;

    logic [10:0] x_end;   // one past the right edge without wrap
    logic        in_x;
    logic        in_y;
    coord_t      dx;
    coord_t      dy;
    coord_t      col;
    coord_t      row;

    logic        s1_hit;
    logic        s1_bright;
    coord_t      s1_x;
    coord_t      s1_y;

    logic        opaque;
    rgb888_t     expanded;
    rgb888_t     color;

    // stage 1 window test and scaled index
    always_comb begin
        x_end = {1'b0, obstacle_x} + 11'(SPRITE_W * SCALE);
        in_x  = (hcount >= obstacle_x) && ({1'b0, hcount} < x_end);
        in_y  = (vcount >= OBSTACLE_Y) && (vcount < OBSTACLE_Y + coord_t'(SPRITE_H * SCALE));
        dx    = hcount - obstacle_x;
        dy    = vcount - OBSTACLE_Y;
        col   = dx / coord_t'(SCALE);
        row   = dy / coord_t'(SCALE);
    end

    assign sprite_idx = sprite_idx_t'(row * SPRITE_W + col);  // word is back next cycle

    always_ff @(posedge pix_clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_hit    <= 1'b0;
            s1_bright <= 1'b0;
        end else begin
            s1_hit    <= in_x && in_y && bright;  // never opaque in blanking
            s1_bright <= bright;
        end
    end

    always_ff @(posedge pix_clk) begin
        s1_x <= hcount;
        s1_y <= vcount;
    end

    // stage 2 colour key and expansion
    always_comb begin
        expanded.r = {sprite_data[15:11], sprite_data[15:13]};
        expanded.g = {sprite_data[10:5], sprite_data[10:9]};
        expanded.b = {sprite_data[4:0], sprite_data[4:2]};
        opaque     = s1_hit && (sprite_data != TRANSPARENT_565);
        if (opaque) begin
            color = expanded;
        end else if (s1_bright) begin
            color = BG_COLOR;
        end else begin
            color = '0;  // black in blanking
        end
    end

    always_ff @(posedge pix_clk or negedge rst_n) begin
        if (!rst_n) begin
            pixel_out <= '0;
        end else begin
            pixel_out.x      <= s1_x;
            pixel_out.y      <= s1_y;
            pixel_out.bright <= s1_bright;
            pixel_out.opaque <= opaque;
            pixel_out.color  <= color;
        end
    end

endmodule

// ==== rtl/sprite_pkg.sv ====
// shared video, sprite and bus types and constants, imported by every design file and the testbench
package sprite_pkg;

    typedef logic [9:0]  coord_t;       // screen counter or position
    typedef logic [15:0] rgb565_t;      // stored sprite pixel
    typedef logic [5:0]  sprite_idx_t;  // word index into sprite memory
    typedef logic [6:0]  wb_adr_t;      // bus word address
    typedef logic [15:0] wb_dat_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb888_t;

    typedef struct packed {
        coord_t  x;
        coord_t  y;
        logic    bright;
        logic    opaque;
        rgb888_t color;
    } pixel_out_t;

    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        wb_adr_t adr;
        wb_dat_t dat;
    } wb_req_t;

    localparam int SPRITE_W = 8;
    localparam int SPRITE_H = 8;
    localparam int SCALE    = 4;
    localparam coord_t OBSTACLE_Y = 10'd224;  // centres the 32 scaled lines

    localparam int H_ACTIVE = 640;
    localparam int H_FP     = 16;
    localparam int H_SYNC   = 96;
    localparam int H_TOTAL  = 800;
    localparam int V_ACTIVE = 480;
    localparam int V_FP     = 10;
    localparam int V_SYNC   = 2;
    localparam int V_TOTAL  = 525;

    localparam rgb565_t TRANSPARENT_565 = 16'hF81F;  // magenta key
    localparam rgb888_t BG_COLOR        = 24'h88CC88;
    localparam wb_adr_t ADR_POS_X       = 7'd64;     // 0..63 are sprite words

endpackage

// ==== rtl/sprite_ram.sv ====
// 64-word RGB565 sprite store with a bus read/write port and a pixel read port
module sprite_ram (
    input  logic                    pix_clk,
    input  logic                    we,
    input  sprite_pkg::sprite_idx_t bus_idx,
    input  sprite_pkg::rgb565_t     bus_wdata,
    input  sprite_pkg::sprite_idx_t pix_idx,
    output sprite_pkg::rgb565_t     bus_rdata,
    output sprite_pkg::rgb565_t     pix_rdata
);

    import sprite_pkg::*;

    rgb565_t mem [SPRITE_W * SPRITE_H];

    // read-before-write on the bus port
    always_ff @(posedge pix_clk) begin
        if (we) begin
            mem[bus_idx] <= bus_wdata;
        end
        bus_rdata <= mem[bus_idx];
    end

    always_ff @(posedge pix_clk) begin
        pix_rdata <= mem[pix_idx];
    end

endmodule

// ==== rtl/sprite_video_top.sv ====
// sprite video top level joining bus registers, sprite memory, scan timing and bit generator
module sprite_video_top (
    input  logic                   pix_clk,
    input  logic                   rst_n,
    input  sprite_pkg::wb_req_t    wb_req,
    output sprite_pkg::wb_dat_t    wb_dat_r,
    output logic                   wb_ack,
    output logic                   hsync,
    output logic                   vsync,
    output sprite_pkg::pixel_out_t pixel_out
);

    import sprite_pkg::*;

    coord_t      hcount;
    coord_t      vcount;
    logic        bright;
    coord_t      obstacle_x;
    logic        ram_we;
    sprite_idx_t ram_idx;
    rgb565_t     ram_wdata;
    rgb565_t     ram_rdata;
    sprite_idx_t pix_idx;
    rgb565_t     pix_rdata;

    vga_timing vga_timing_inst (
        .pix_clk (pix_clk),
        .rst_n   (rst_n),
        .hcount  (hcount),
        .vcount  (vcount),
        .bright  (bright),
        .hsync   (hsync),   // undelayed
        .vsync   (vsync)
    );

    wb_sprite_regs wb_sprite_regs_inst (
        .pix_clk    (pix_clk),
        .rst_n      (rst_n),
        .wb_req     (wb_req),
        .ram_rdata  (ram_rdata),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .ram_we     (ram_we),
        .ram_idx    (ram_idx),
        .ram_wdata  (ram_wdata),
        .obstacle_x (obstacle_x)
    );

    sprite_ram sprite_ram_inst (
        .pix_clk   (pix_clk),
        .we        (ram_we),
        .bus_idx   (ram_idx),
        .bus_wdata (ram_wdata),
        .pix_idx   (pix_idx),
        .bus_rdata (ram_rdata),
        .pix_rdata (pix_rdata)
    );

    obstacle_sprite obstacle_sprite_inst (
        .pix_clk     (pix_clk),
        .rst_n       (rst_n),
        .hcount      (hcount),
        .vcount      (vcount),
        .bright      (bright),
        .obstacle_x  (obstacle_x),
        .sprite_data (pix_rdata),
        .sprite_idx  (pix_idx),
        .pixel_out   (pixel_out)
    );

endmodule

// ==== rtl/vga_timing.sv ====
// 640x480 scan generator with free-running counters and registered active-low syncs
module vga_timing (
    input  logic               pix_clk,
    input  logic               rst_n,
    output sprite_pkg::coord_t hcount,
    output sprite_pkg::coord_t vcount,
    output logic               bright,
    output logic               hsync,
    output logic               vsync
);

    import sprite_pkg::*;

    coord_t h_next;
    coord_t v_next;
    logic   hsync_next;
    logic   vsync_next;

    always_comb begin
        h_next = hcount + coord_t'(1);
        v_next = vcount;
        if (hcount == coord_t'(H_TOTAL - 1)) begin
            h_next = '0;
            if (vcount == coord_t'(V_TOTAL - 1)) begin
                v_next = '0;
            end else begin
                v_next = vcount + coord_t'(1);
            end
        end
    end

    // decode on the next count so the pulses line up with the counters
    always_comb begin
        hsync_next = !((h_next >= coord_t'(H_ACTIVE + H_FP)) &&
                       (h_next <  coord_t'(H_ACTIVE + H_FP + H_SYNC)));
        vsync_next = !((v_next >= coord_t'(V_ACTIVE + V_FP)) &&
                       (v_next <  coord_t'(V_ACTIVE + V_FP + V_SYNC)));
    end

    always_ff @(posedge pix_clk or negedge rst_n) begin
        if (!rst_n) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b1;
            vsync  <= 1'b1;
        end else begin
            hcount <= h_next;
            vcount <= v_next;
            hsync  <= hsync_next;
            vsync  <= vsync_next;
        end
    end

    assign bright = (hcount < coord_t'(H_ACTIVE)) && (vcount < coord_t'(V_ACTIVE));

endmodule

// ==== rtl/wb_sprite_regs.sv ====
// Wishbone classic slave for loading sprite words and the obstacle x position
module wb_sprite_regs (
    input  logic                    pix_clk,
    input  logic                    rst_n,
    input  sprite_pkg::wb_req_t     wb_req,
    input  sprite_pkg::rgb565_t     ram_rdata,
    output sprite_pkg::wb_dat_t     wb_dat_r,
    output logic                    wb_ack,
    output logic                    ram_we,
    output sprite_pkg::sprite_idx_t ram_idx,
    output sprite_pkg::rgb565_t     ram_wdata,
    output sprite_pkg::coord_t      obstacle_x
);

    import sprite_pkg::*;

    logic req;
    logic is_sprite;
    logic is_pos;
    logic sel_ram;   // ack cycle returns memory word
    logic sel_pos;   // ack cycle returns position

    // new request only while ack is low so each strobe is served once
    assign req       = wb_req.cyc && wb_req.stb && !wb_ack;
    assign is_sprite = wb_req.adr < wb_adr_t'(SPRITE_W * SPRITE_H);
    assign is_pos    = wb_req.adr == ADR_POS_X;

    // memory port follows the bus directly so read data lands in the ack cycle
    assign ram_we    = req && wb_req.we && is_sprite;
    assign ram_idx   = sprite_idx_t'(wb_req.adr);
    assign ram_wdata = wb_req.dat;

    always_ff @(posedge pix_clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack     <= 1'b0;
            sel_ram    <= 1'b0;
            sel_pos    <= 1'b0;
            obstacle_x <= '0;
        end else begin
            wb_ack  <= req;
            sel_ram <= req && !wb_req.we && is_sprite;
            sel_pos <= req && !wb_req.we && is_pos;
            if (req && wb_req.we && is_pos) begin
                obstacle_x <= coord_t'(wb_req.dat);  // low 10 bits
            end
        end
    end

    always_comb begin
        if (sel_ram) begin
            wb_dat_r = ram_rdata;
        end else if (sel_pos) begin
            wb_dat_r = wb_dat_t'(obstacle_x);
        end else begin
            wb_dat_r = '0;  // unmapped or write
        end
    end

endmodule

// ==== sim/tb_sprite_video.sv ====
// testbench that loads sprite words over the bus and probes pixels listed in the testdata file
module tb_sprite_video;

    import sprite_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;

    logic       pix_clk;
    logic       rst_n;
    wb_req_t    wb_req;
    wb_dat_t    wb_dat_r;
    logic       wb_ack;
    logic       hsync;
    logic       vsync;
    pixel_out_t pixel_out;

    logic [63:0] records [0:63];  // kind, a, b, flags, value
    rgb565_t     shadow [SPRITE_W * SPRITE_H];
    int          pos_count;
    coord_t      cur_x;           // obstacle position held by the DUT

    sprite_video_top sprite_video_top_inst (
        .pix_clk   (pix_clk),
        .rst_n     (rst_n),
        .wb_req    (wb_req),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .hsync     (hsync),
        .vsync     (vsync),
        .pixel_out (pixel_out)
    );

    initial begin
        pix_clk = 1'b0;
        forever #(CLK_PERIOD / 2) pix_clk = ~pix_clk;
    end

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_pixel(input string name, input pixel_out_t got, input pixel_out_t exp);
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bus(input string name, input wb_dat_t got, input wb_dat_t exp);
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_coord(input string name, input coord_t got, input coord_t exp);
        if (got !== exp) begin
            $display("** Error: %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // one classic cycle with ack for exactly one cycle, one cycle after stb
    task automatic bus_cycle(input logic we, input wb_adr_t adr, input wb_dat_t dat,
                             output wb_dat_t rdata);
        @(posedge pix_clk);
        #1;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        @(negedge pix_clk);
        if (wb_ack) begin
            $display("ack came in the same cycle as stb, address %h", adr);
            abort_run();
        end
        @(negedge pix_clk);
        if (!wb_ack) begin
            $display("no ack one cycle after stb, address %h", adr);
            abort_run();
        end
        rdata = wb_dat_r;
        @(posedge pix_clk);
        #1;
        wb_req = '0;
        @(negedge pix_clk);
        if (wb_ack) begin
            $display("ack held for more than one cycle, address %h", adr);
            abort_run();
        end
    endtask

    // reference pixel from the window, scale, colour key and expansion rules
    function automatic pixel_out_t model_pixel(input coord_t x, input coord_t y, input coord_t ox);
        pixel_out_t p;
        int         dx;
        int         dy;
        int         r5;
        int         g6;
        int         b5;
        rgb565_t    w;
        p        = '0;
        p.x      = x;
        p.y      = y;
        p.bright = (x < H_ACTIVE) && (y < V_ACTIVE);
        dx       = int'(x) - int'(ox);
        dy       = int'(y) - int'(OBSTACLE_Y);
        if (p.bright && dx >= 0 && dx < SPRITE_W * SCALE && dy >= 0 && dy < SPRITE_H * SCALE) begin
            w        = shadow[(dy / SCALE) * SPRITE_W + dx / SCALE];
            p.opaque = (w != TRANSPARENT_565);
        end
        if (p.opaque) begin
            r5      = (w >> 11) & 31;
            g6      = (w >> 5) & 63;
            b5      = w & 31;
            p.color = '{r: 8'((r5 << 3) | (r5 >> 2)), g: 8'((g6 << 2) | (g6 >> 4)),
                        b: 8'((b5 << 3) | (b5 >> 2))};
        end else if (p.bright) begin
            p.color = BG_COLOR;
        end
        return p;
    endfunction

    initial begin
        logic [63:0] rec;
        wb_dat_t     rd;
        pixel_out_t  exp;
        pixel_out_t  want;
        int          seed;
        int          n;
        rst_n     = 1'b0;
        wb_req    = '0;
        cur_x     = '0;
        pos_count = 0;
        seed      = 32'he5a0_9ddb;
        void'($urandom(seed));
        for (n = 0; n < 64; n++) records[n] = '0;
        $readmemh("sim/testdata_sprite.txt", records);
        foreach (shadow[i]) begin
            shadow[i] = rgb565_t'($urandom);
            if (shadow[i] == TRANSPARENT_565) shadow[i] = ~shadow[i];
        end
        for (n = 0; n < 64 && records[n][63:60] != 4'h0; n++) begin
            if (records[n][63:60] == 4'h2) pos_count++;
        end
        repeat (3) @(posedge pix_clk);
        #1 rst_n = 1'b1;

        foreach (shadow[i]) bus_cycle(1'b1, wb_adr_t'(i), shadow[i], rd);
        for (n = 0; n < 64 && records[n][63:60] != 4'h0; n++) begin
            rec = records[n];
            if (rec[63:60] == 4'h1) begin  // override on top of the random image
                shadow[rec[53:48]] = rec[15:0];
                bus_cycle(1'b1, wb_adr_t'(rec[59:48]), rec[15:0], rd);
            end
        end
        foreach (shadow[i]) begin
            bus_cycle(1'b0, wb_adr_t'(i), '0, rd);
            check_bus("wb_dat_r", rd, shadow[i]);
        end
        bus_cycle(1'b1, 7'd100, 16'hdead, rd);  // unmapped write is dropped
        bus_cycle(1'b0, 7'd100, '0, rd);
        check_bus("wb_dat_r", rd, '0);
        bus_cycle(1'b0, 7'd127, '0, rd);
        check_bus("wb_dat_r", rd, '0);
        bus_cycle(1'b1, ADR_POS_X, 16'hffff, rd);
        bus_cycle(1'b0, ADR_POS_X, '0, rd);
        check_bus("wb_dat_r", rd, 16'h03ff);

        // pixel_out.x trails the hsync fall by two cycles
        do @(negedge pix_clk); while (!hsync);
        do @(negedge pix_clk); while (hsync);
        repeat (2) @(negedge pix_clk);
        check_coord("pixel_out.x", pixel_out.x, coord_t'(H_ACTIVE + H_FP));

        // vsync falls at the start of its line
        do @(negedge pix_clk); while (!vsync);
        do @(negedge pix_clk); while (vsync);
        repeat (2) @(negedge pix_clk);
        check_coord("pixel_out.y", pixel_out.y, coord_t'(V_ACTIVE + V_FP));
        check_coord("pixel_out.x", pixel_out.x, coord_t'(0));

        for (n = 0; n < 64 && records[n][63:60] != 4'h0; n++) begin
            rec = records[n];
            if (rec[63:60] == 4'h2) begin
                cur_x = coord_t'(rec[31:0]);
                bus_cycle(1'b1, ADR_POS_X, rec[15:0], rd);
                bus_cycle(1'b0, ADR_POS_X, '0, rd);
                check_bus("wb_dat_r", rd, wb_dat_t'(cur_x));
                do @(negedge pix_clk); while (pixel_out.x != '0 || pixel_out.y != '0);
            end else if (rec[63:60] == 4'h3) begin
                exp  = model_pixel(coord_t'(rec[59:48]), coord_t'(rec[47:36]), cur_x);
                want = {exp.x, exp.y, rec[33], rec[32], rec[23:0]};
                check_pixel("testdata expected", want, exp);
                do @(negedge pix_clk); while (pixel_out.x != exp.x || pixel_out.y != exp.y);
                check_pixel("pixel_out", pixel_out, exp);
            end
        end
        $display("Regression passed");
        $finish;
    end

    // two frames per position record plus the bus phase
    initial begin
        longint limit;
        @(posedge rst_n);
        limit = longint'(pos_count) * 2 * FRAME_CYCLES * CLK_PERIOD + 200_000;
        #(limit);
        $display("timeout: the probe points were never reached");
        abort_run();
    end

endmodule

// ==== sim/testdata_sprite.txt ====
// columns: kind_a_b_flags_value. kind 1 sprite write (a index, value word), 2 obstacle x (value),
// kind 3 probe (a x, b y, flags {bright,opaque}, value rgb888), kind 0 ends the list
1_000_000_0_0000ffff
1_007_000_0_0000001f
1_009_000_0_0000f81f
1_01b_000_0_00008410
1_038_000_0_0000f800
1_03f_000_0_000007e0
2_000_000_0_00000064
3_290_064_0_00000000
3_063_0e0_2_0088cc88
3_064_0e0_3_00ffffff
3_083_0e0_3_000000ff
3_084_0e0_2_0088cc88
3_067_0e3_3_00ffffff
3_069_0e5_2_0088cc88
3_071_0ec_3_00848284
3_064_0ff_3_00ff0000
3_083_0ff_3_0000ff00
3_0c8_1e0_0_00000000
2_000_000_0_00000190
3_064_0e0_2_0088cc88
3_18f_0e0_2_0088cc88
3_190_0e0_3_00ffffff
3_1af_0e0_3_000000ff
3_1b0_0e0_2_0088cc88
0_000_000_0_00000000
